// ==== flist.f ====
logic/soc_io_pkg.sv
logic/io_bus_decoder.sv
logic/data_ram.sv
logic/gpio_port.sv
logic/timer_counter.sv
logic/display_mux.sv
logic/soc_io_top.sv
verif/soc_io_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module soc_io_tb -Mdir obj_dir -f flist.f
	./obj_dir/Vsoc_io_tb | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/soc_io_tb.sv ====
module soc_io_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import soc_io_pkg::*;

    logic       clk_100mhz = 1'b0;
    logic       rst;
    word_t      addr;
    word_t      wdata;
    logic       mem_w;
    logic       mem_rd;
    sw_t        sw;
    btn_t       btn;
    word_t      rdata;
    led_t       led;
    logic [2:0] counter_flags;
    word_t      disp_num;

    // Reference model state
    word_t      m_ram [RAM_DEPTH];
    led_t       m_led;
    chan_sel_t  m_chan_sel;
    word_t      m_disp_reg;
    word_t      m_count [3];
    logic [2:0] m_flags;
    logic [5:0] m_prescale;
    word_t      m_rdata;
    word_t      m_disp_num;

    sw_t        next_sw;
    btn_t       next_btn;
    integer     seed = 85;
    int         err_count = 0;
    int         test_err_start = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         wr_q [$];

    soc_io_top u_soc_io_top (
        .clk_100mhz    (clk_100mhz),
        .rst           (rst),
        .addr          (addr),
        .wdata         (wdata),
        .mem_w         (mem_w),
        .mem_rd        (mem_rd),
        .sw            (sw),
        .btn           (btn),
        .rdata         (rdata),
        .led           (led),
        .counter_flags (counter_flags),
        .disp_num      (disp_num)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic is_mapped(input word_t a);
        return (a < ADDR_RAM_LIMIT) || (a == ADDR_DISP) || (a == ADDR_GPIO)
            || (a == ADDR_COUNTER);
    endfunction

    // Select 3 has no channel and reads as zero
    function automatic word_t expected_counter();
        if (m_chan_sel < 2'd3) begin
            return m_count[m_chan_sel];
        end
        return '0;
    endfunction

    function automatic word_t expected_read(input word_t a, input sw_t s, input btn_t b);
        word_t w;
        w = '0;
        if (a < ADDR_RAM_LIMIT) begin
            w = m_ram[a[11:2]];
        end else if (a == ADDR_GPIO) begin
            w[31:29] = m_flags;
            w[20:16] = b;
            w[15:0]  = s;
        end else if (a == ADDR_COUNTER) begin
            w = expected_counter();
        end
        return w;
    endfunction

    task automatic reset_model();
        m_led      = '0;
        m_chan_sel = '0;
        m_disp_reg = '0;
        m_flags    = '0;
        m_prescale = '0;
        m_rdata    = '0;
        m_disp_num = '0;
        for (int k = 0; k < 3; k++) begin
            m_count[k] = '0;
        end
    endtask

    // Advances the model by one clock edge using the state before it
    task automatic step_model(input logic w, input logic r, input word_t a, input word_t d,
                              input sw_t s, input btn_t b);
        word_t      rd_word;
        word_t      disp_next;
        chan_sel_t  old_sel;
        logic [5:0] mask;
        logic       tick;
        old_sel = m_chan_sel;
        rd_word = expected_read(a, s, b);
        case (s[7:5])
            3'd0:    disp_next = m_disp_reg;
            3'd1:    disp_next = word_t'(m_led);
            3'd2:    disp_next = expected_counter();
            3'd3:    disp_next = a;
            3'd4:    disp_next = d;
            3'd5:    disp_next = m_rdata;
            3'd6:    disp_next = word_t'(s);
            default: disp_next = word_t'(m_flags);
        endcase
        for (int k = 0; k < 3; k++) begin
            mask = 6'((32'd1 << PRESCALE_BITS[k]) - 32'd1);
            tick = ((m_prescale & mask) == mask);
            if (w && (a == ADDR_COUNTER) && (old_sel == chan_sel_t'(k))) begin
                m_count[k] = d;
                m_flags[k] = 1'b0;
            end else if (tick && (m_count[k] != '0)) begin
                if (m_count[k] == word_t'(1)) begin
                    m_flags[k] = 1'b1;
                end
                m_count[k] = m_count[k] - word_t'(1);
            end
        end
        if (w && (a < ADDR_RAM_LIMIT)) begin
            m_ram[a[11:2]] = d;
        end
        if (w && (a == ADDR_GPIO)) begin
            m_led      = d[17:2];
            m_chan_sel = d[1:0];
        end
        if (w && (a == ADDR_DISP)) begin
            m_disp_reg = d;
        end
        m_prescale = m_prescale + 6'd1;
        if (r) begin
            m_rdata = rd_word;
        end
        m_disp_num = disp_next;
    endtask

    //////////////////////////////
    // Bus driver and checks
    //////////////////////////////

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_outputs();
        check_word("rdata", m_rdata, rdata);
        check_word("led", word_t'(m_led), word_t'(led));
        check_word("counter_flags", word_t'(m_flags), word_t'(counter_flags));
        check_word("disp_num", m_disp_num, disp_num);
    endtask

    // Drives one bus cycle and checks the state left by the previous edge
    task automatic bus_cycle(input logic w, input logic r, input word_t a, input word_t d);
        @(posedge clk_100mhz);
        rst    <= 1'b0;
        addr   <= a;
        wdata  <= d;
        mem_w  <= w;
        mem_rd <= r;
        sw     <= next_sw;
        btn    <= next_btn;
        @(negedge clk_100mhz);
        compare_outputs();
        step_model(w, r, a, d, next_sw, next_btn);
    endtask

    task automatic end_test(input string name);
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, err_count - test_err_start);
        end
        test_err_start = err_count;
    endtask

    initial begin
        word_t a;
        word_t d;
        int    idx;
        int    n;
        int    count;
        rst      = 1'b1;
        addr     = '0;
        wdata    = '0;
        mem_w    = 1'b0;
        mem_rd   = 1'b0;
        sw       = '0;
        btn      = '0;
        next_sw  = '0;
        next_btn = '0;
        reset_model();
        // Fourth reset edge comes with the first bus cycle
        repeat (3) @(posedge clk_100mhz);

        bus_cycle(1'b0, 1'b0, '0, '0);
        check_word("led", '0, word_t'(led));
        check_word("counter_flags", '0, word_t'(counter_flags));
        check_word("disp_num", '0, disp_num);
        bus_cycle(1'b0, 1'b1, ADDR_GPIO, '0);
        bus_cycle(1'b0, 1'b1, ADDR_COUNTER, '0);
        bus_cycle(1'b0, 1'b1, ADDR_DISP, '0);
        bus_cycle(1'b0, 1'b0, '0, '0);
        check_word("rdata", '0, rdata);
        end_test("reset_values");

        // Writes mixed with up to three back-to-back reads
        for (int i = 0; i < 200; i++) begin
            d        = $random(seed);
            idx      = int'(d[9:0]);
            next_sw  = $random(seed);
            next_btn = $random(seed);
            bus_cycle(1'b1, 1'b0, word_t'(idx) << 2, $random(seed));
            wr_q.push_back(idx);
            d = $random(seed);
            for (int j = 0; j < int'(d[1:0]); j++) begin
                idx = wr_q[{$random(seed)} % wr_q.size()];
                bus_cycle(1'b0, 1'b1, word_t'(idx) << 2, '0);
            end
        end
        bus_cycle(1'b0, 1'b0, '0, '0);
        end_test("data_ram");

        for (int i = 0; i < 40; i++) begin
            next_sw  = $random(seed);
            next_btn = $random(seed);
            d        = $random(seed);
            bus_cycle(1'b1, 1'b0, ADDR_GPIO, d);
            bus_cycle(1'b0, 1'b1, ADDR_GPIO, '0);
        end
        bus_cycle(1'b0, 1'b0, '0, '0);
        check_word("led", word_t'(d[17:2]), word_t'(led));
        end_test("gpio");

        for (int k = 0; k < 3; k++) begin
            bus_cycle(1'b1, 1'b0, ADDR_GPIO, word_t'(k));
            d     = $random(seed);
            count = int'(d[2:0]) + 1;
            bus_cycle(1'b1, 1'b0, ADDR_COUNTER, word_t'(count));
            n = 0;
            while ((counter_flags[k] !== 1'b1) && (n < 1000)) begin
                bus_cycle(1'b0, 1'b1, ADDR_COUNTER, '0);
                n++;
            end
            if (counter_flags[k] !== 1'b1) begin
                $display("Counter channel %0d flag did not rise within 1000 cycles", k);
                err_count++;
            end
            // Reload must drop the flag
            bus_cycle(1'b1, 1'b0, ADDR_COUNTER, word_t'(count + 4));
            bus_cycle(1'b0, 1'b1, ADDR_COUNTER, '0);
            check_word($sformatf("counter_flags[%0d]", k), '0, word_t'(counter_flags[k]));
        end
        bus_cycle(1'b1, 1'b0, ADDR_GPIO, 32'h3);
        bus_cycle(1'b1, 1'b0, ADDR_COUNTER, 32'h55);
        bus_cycle(1'b0, 1'b1, ADDR_COUNTER, '0);
        bus_cycle(1'b0, 1'b0, '0, '0);
        check_word("rdata", '0, rdata);
        end_test("counters");

        for (int i = 0; i < 60; i++) begin
            next_sw = $random(seed);
            d       = $random(seed);
            bus_cycle(d[0], 1'b0, ADDR_DISP, $random(seed));
            bus_cycle(1'b0, d[1], ADDR_GPIO, '0);
        end
        bus_cycle(1'b0, 1'b0, '0, '0);
        end_test("display_mux");

        for (int i = 0; i < 40; i++) begin
            a = $random(seed);
            if (is_mapped(a)) begin
                a = a | 32'h0000_1008;
            end
            bus_cycle(1'b1, 1'b0, a, $random(seed));
            bus_cycle(1'b0, 1'b1, a, '0);
            bus_cycle(1'b0, 1'b0, '0, '0);
            check_word("rdata", '0, rdata);
        end
        // Read back RAM words written earlier
        for (int i = 0; i < 20; i++) begin
            idx = wr_q[{$random(seed)} % wr_q.size()];
            bus_cycle(1'b0, 1'b1, word_t'(idx) << 2, '0);
        end
        bus_cycle(1'b0, 1'b0, '0, '0);
        end_test("unmapped");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if ((tests_failed == 0) && (err_count == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/soc_io_top.sv ====
module soc_io_top (
    input  logic                            clk_100mhz,
    input  logic                            rst,
    input  soc_io_pkg::word_t               addr,
    input  soc_io_pkg::word_t               wdata,
    input  logic                            mem_w,
    input  logic                            mem_rd,
    input  soc_io_pkg::sw_t                 sw,
    input  soc_io_pkg::btn_t                btn,
    output soc_io_pkg::word_t               rdata,
    output soc_io_pkg::led_t                led,
    output logic [soc_io_pkg::NUM_CHAN-1:0] counter_flags,
    output soc_io_pkg::word_t               disp_num
);

    import soc_io_pkg::*;

    // Bus decoder to RAM
    logic      ram_we;
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;

    // Peripheral strobes
    logic gpio_we;
    logic counter_we;
    logic disp_we;

    // Peripheral state back to the bus
    chan_sel_t chan_sel;
    word_t     counter_value;

    io_bus_decoder u_io_bus_decoder (
        .clk_100mhz    (clk_100mhz),
        .rst           (rst),
        .addr          (addr),
        .wdata         (wdata),
        .mem_w         (mem_w),
        .mem_rd        (mem_rd),
        .ram_rdata     (ram_rdata),
        .sw            (sw),
        .btn           (btn),
        .chan_sel      (chan_sel),
        .counter_value (counter_value),
        .counter_flags (counter_flags),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .gpio_we       (gpio_we),
        .counter_we    (counter_we),
        .disp_we       (disp_we),
        .rdata         (rdata)
    );

    data_ram u_data_ram (
        .clk_100mhz (clk_100mhz),
        .we         (ram_we),
        .addr       (ram_addr),
        .wdata      (ram_wdata),
        .rdata      (ram_rdata)
    );

    gpio_port u_gpio_port (
        .clk_100mhz (clk_100mhz),
        .rst        (rst),
        .we         (gpio_we),
        .wdata      (wdata),
        .led        (led),
        .chan_sel   (chan_sel)
    );

    timer_counter u_timer_counter (
        .clk_100mhz    (clk_100mhz),
        .rst           (rst),
        .we            (counter_we),
        .chan_sel      (chan_sel),
        .wdata         (wdata),
        .counter_value (counter_value),
        .flags         (counter_flags)
    );

    // Switches 7..5 pick the panel channel
    display_mux u_display_mux (
        .clk_100mhz    (clk_100mhz),
        .rst           (rst),
        .we            (disp_we),
        .wdata         (wdata),
        .sel           (disp_sel_t'(sw[7:5])),
        .led           (led),
        .counter_value (counter_value),
        .flags         (counter_flags),
        .rdata         (rdata),
        .addr          (addr),
        .sw            (sw),
        .disp_num      (disp_num)
    );

endmodule

// ==== logic/display_mux.sv ====
module display_mux (
    input  logic                            clk_100mhz,
    input  logic                            rst,
    input  logic                            we,
    input  soc_io_pkg::word_t               wdata,
    input  soc_io_pkg::disp_sel_t           sel,
    input  soc_io_pkg::led_t                led,
    input  soc_io_pkg::word_t               counter_value,
    input  logic [soc_io_pkg::NUM_CHAN-1:0] flags,
    input  soc_io_pkg::word_t               rdata,
    input  soc_io_pkg::word_t               addr,
    input  soc_io_pkg::sw_t                 sw,
    output soc_io_pkg::word_t               disp_num
);

    import soc_io_pkg::*;

    word_t disp_reg_q;
    word_t disp_next;

    // Display data register at ADDR_DISP
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            disp_reg_q <= '0;
        end else if (we) begin
            disp_reg_q <= wdata;
        end
    end

    //////////////////////////////
    // Eight-way selector
    //////////////////////////////

    always_comb begin
        case (sel)
            3'd0:    disp_next = disp_reg_q;
            3'd1:    disp_next = word_t'(led);
            3'd2:    disp_next = counter_value;
            3'd3:    disp_next = addr;
            3'd4:    disp_next = wdata;
            3'd5:    disp_next = rdata;
            3'd6:    disp_next = word_t'(sw);
            default: disp_next = word_t'(flags);
        endcase
    end

    // Registered so the panel sees a stable word
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            disp_num <= '0;
        end else begin
            disp_num <= disp_next;
        end
    end

endmodule

// ==== logic/timer_counter.sv ====
module timer_counter (
    input  logic                                clk_100mhz,
    input  logic                                rst,
    input  logic                                we,
    input  soc_io_pkg::chan_sel_t               chan_sel,
    input  soc_io_pkg::word_t                   wdata,
    output soc_io_pkg::word_t                   counter_value,
    output logic [soc_io_pkg::NUM_CHAN-1:0]     flags
);

    import soc_io_pkg::*;

    logic [PRESCALE_W-1:0] prescale_q;
    logic [NUM_CHAN-1:0]   tick;
    logic [NUM_CHAN-1:0]   flag_q;
    word_t                 count_q [NUM_CHAN];

    //////////////////////////////
    // Prescaler and ticks
    //////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            prescale_q <= '0;
        end else begin
            prescale_q <= prescale_q + 1'b1;
        end
    end

    // Channel k ticks once its low PRESCALE_BITS[k] bits are all ones
    always_comb begin
        logic [PRESCALE_W-1:0] mask;
        for (int i = 0; i < NUM_CHAN; i++) begin
            mask = (PRESCALE_W'(1) << PRESCALE_BITS[i]) - 1'b1;
            tick[i] = ((prescale_q & mask) == mask);
        end
    end

    //////////////////////////////
    // Down-counters
    //////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                count_q[i] <= '0;
            end
            flag_q <= '0;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (we && (chan_sel == chan_sel_t'(i))) begin
                    // Reload wins over a tick in the same cycle
                    count_q[i] <= wdata;
                    flag_q[i]  <= 1'b0;
                end else if (tick[i] && (count_q[i] != '0)) begin
                    count_q[i] <= count_q[i] - 1'b1;
                    if (count_q[i] == word_t'(1)) begin
                        flag_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // Select value 3 has no channel behind it
    always_comb begin
        case (chan_sel)
            2'd0:    counter_value = count_q[0];
            2'd1:    counter_value = count_q[1];
            2'd2:    counter_value = count_q[2];
            default: counter_value = '0;
        endcase
    end

    assign flags = flag_q;

endmodule

// ==== logic/gpio_port.sv ====
module gpio_port (
    input  logic                  clk_100mhz,
    input  logic                  rst,
    input  logic                  we,
    input  soc_io_pkg::word_t     wdata,
    output soc_io_pkg::led_t      led,
    output soc_io_pkg::chan_sel_t chan_sel
);

    import soc_io_pkg::*;

    // Field split of the GPIO write word
    //   [17:2] LED levels
    //   [1:0]  counter channel select
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            led      <= '0;
            chan_sel <= '0;
        end else if (we) begin
            led      <= led_t'(wdata[17:2]);
            chan_sel <= chan_sel_t'(wdata[1:0]);
        end
    end

endmodule

// ==== logic/data_ram.sv ====
module data_ram (
    input  logic                  clk_100mhz,
    input  logic                  we,
    input  soc_io_pkg::ram_addr_t addr,
    input  soc_io_pkg::word_t     wdata,
    output soc_io_pkg::word_t     rdata
);

    import soc_io_pkg::*;

    word_t mem [RAM_DEPTH];

    // Single port, read register updated every cycle
    always_ff @(posedge clk_100mhz) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== logic/io_bus_decoder.sv ====
module io_bus_decoder (
    input  logic                            clk_100mhz,
    input  logic                            rst,
    input  soc_io_pkg::word_t               addr,
    input  soc_io_pkg::word_t               wdata,
    input  logic                            mem_w,
    input  logic                            mem_rd,
    input  soc_io_pkg::word_t               ram_rdata,
    input  soc_io_pkg::sw_t                 sw,
    input  soc_io_pkg::btn_t                btn,
    input  soc_io_pkg::chan_sel_t           chan_sel,
    input  soc_io_pkg::word_t               counter_value,
    input  logic [soc_io_pkg::NUM_CHAN-1:0] counter_flags,
    output logic                            ram_we,
    output soc_io_pkg::ram_addr_t           ram_addr,
    output soc_io_pkg::word_t               ram_wdata,
    output logic                            gpio_we,
    output logic                            counter_we,
    output logic                            disp_we,
    output soc_io_pkg::word_t               rdata
);

    import soc_io_pkg::*;

    logic  ram_hit;
    logic  disp_hit;
    logic  gpio_hit;
    logic  counter_hit;
    word_t gpio_word;
    word_t periph_word;
    logic  rd_ram_q;
    word_t rd_word_q;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign ram_hit     = (addr < ADDR_RAM_LIMIT);
    assign disp_hit    = (addr == ADDR_DISP);
    assign gpio_hit    = (addr == ADDR_GPIO);
    assign counter_hit = (addr == ADDR_COUNTER);

    // One strobe per mapped write, nothing for unmapped addresses
    assign ram_we  = mem_w & ram_hit;
    assign gpio_we = mem_w & gpio_hit;
    assign disp_we = mem_w & disp_hit;
    // No channel to load when select is 3
    assign counter_we = mem_w & counter_hit & (chan_sel < chan_sel_t'(NUM_CHAN));

    // Word index from byte address
    assign ram_addr  = ram_addr_t'(addr[RAM_ADDR_W+1:2]);
    assign ram_wdata = wdata;

    //////////////////////////////
    // Read path
    //////////////////////////////

    // Flags 2..0 on top, then buttons and switches
    assign gpio_word = {counter_flags, 8'h00, btn, sw};

    always_comb begin
        if (gpio_hit) begin
            periph_word = gpio_word;
        end else if (counter_hit) begin
            periph_word = counter_value;
        end else begin
            periph_word = '0;
        end
    end

    // Peripheral words are captured with the strobe; the RAM has its own
    // read register, so its word is passed through for one cycle and then held
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            rd_ram_q  <= 1'b0;
            rd_word_q <= '0;
        end else if (mem_rd) begin
            rd_ram_q  <= ram_hit;
            rd_word_q <= periph_word;
        end else if (rd_ram_q) begin
            rd_ram_q  <= 1'b0;
            rd_word_q <= ram_rdata;
        end
    end

    assign rdata = rd_ram_q ? ram_rdata : rd_word_q;

endmodule

// ==== logic/soc_io_pkg.sv ====
package soc_io_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int RAM_ADDR_W = 10;
    localparam int RAM_DEPTH = 1024;
    localparam int NUM_CHAN = 3;
    localparam int PRESCALE_W = 6;

    typedef logic [31:0] word_t;
    typedef logic [15:0] sw_t;
    typedef logic [4:0] btn_t;
    typedef logic [15:0] led_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [1:0] chan_sel_t;
    typedef logic [2:0] disp_sel_t;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Byte addresses below this hit the data RAM
    localparam word_t ADDR_RAM_LIMIT = 32'h0000_1000;
    localparam word_t ADDR_DISP = 32'he000_0000;
    localparam word_t ADDR_GPIO = 32'hf000_0000;
    localparam word_t ADDR_COUNTER = 32'hf000_0004;

    //////////////////////////////
    // Counter prescaler
    //////////////////////////////

    // Tick widths in bits for channels 2 down to 0
    localparam logic [NUM_CHAN-1:0][2:0] PRESCALE_BITS = {3'd6, 3'd4, 3'd2};

endpackage
